// File: logic/bp_defines.svh
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// Address width of the core, shared by every predictor block
`define BP_XLEN 32

// Default number of BTB entries
// Must stay a power of two, the index is a plain bit slice of the pc
`define BP_BTB_ENTRIES 16

// Default return address stack depth
`define BP_RAS_DEPTH 8

`endif

// File: logic/bp_addr_pkg.sv
`include "bp_defines.svh"

package bp_addr_pkg;

  // Fetch address as seen by the predictor
  typedef logic [`BP_XLEN-1:0] pc_t;

  // Instructions are word aligned, so the two low pc bits carry no information
  localparam int unsigned PC_LSB = 2;

  // Step to the sequential fall-through address
  localparam pc_t INSN_BYTES = pc_t'(4);

endpackage

// File: logic/bp_pred_pkg.sv
`include "bp_defines.svh"

package bp_pred_pkg;

  // Two-bit saturating direction counter, upper bit is the prediction
  typedef enum logic [1:0] {
    strong_nt = 2'd0,
    weak_nt   = 2'd1,
    weak_t    = 2'd2,
    strong_t  = 2'd3
  } ctr_t;

  // Kind of control transfer recorded in a BTB entry
  typedef enum logic [1:0] {
    kind_cond = 2'd0,
    kind_jal  = 2'd1,
    kind_ret  = 2'd2
  } branch_kind_t;

  function automatic logic ctr_taken(ctr_t c);
    return c[1];
  endfunction

  // Counter value for a freshly allocated entry
  function automatic ctr_t ctr_init(logic taken);
    return taken ? weak_t : weak_nt;
  endfunction

  // Saturating train step
  function automatic ctr_t ctr_train(ctr_t c, logic taken);
    ctr_t n;
    n = c;
    if (taken) begin
      if (c != strong_t) n = ctr_t'(c + 2'd1);
    end else if (c != strong_nt) begin
      n = ctr_t'(c - 2'd1);
    end
    return n;
  endfunction

endpackage

// File: logic/btb.sv
`timescale 1ns/1ps

`include "bp_defines.svh"

module btb #(
  parameter int NENTRIES = `BP_BTB_ENTRIES
) (
  input  logic                      clk,
  input  logic                      rst_n,

  // Lookup side, results valid one cycle after lookup_pc is sampled
  input  bp_addr_pkg::pc_t          lookup_pc,
  output logic                      hit,
  output bp_addr_pkg::pc_t          pred_tgt,
  output bp_pred_pkg::ctr_t         pred_ctr,
  output bp_pred_pkg::branch_kind_t pred_kind,
  output bp_addr_pkg::pc_t          lookup_pc_q,

  // Update strobe from the resolve stage
  input  logic                      update_en,
  input  bp_addr_pkg::pc_t          update_pc,
  input  bp_addr_pkg::pc_t          update_tgt,
  input  logic                      update_taken,
  input  bp_pred_pkg::branch_kind_t update_kind
);

  localparam int IDX_W  = $clog2(NENTRIES);
  localparam int IDX_LO = bp_addr_pkg::PC_LSB;
  localparam int TAG_LO = IDX_LO + IDX_W;
  localparam int TAG_W  = `BP_XLEN - TAG_LO;

  // Entry storage, only the valid bits are cleared by reset
  logic                      valid_q  [NENTRIES];
  logic [TAG_W-1:0]          tag_mem  [NENTRIES];
  bp_addr_pkg::pc_t          tgt_mem  [NENTRIES];
  bp_pred_pkg::ctr_t         ctr_mem  [NENTRIES];
  bp_pred_pkg::branch_kind_t kind_mem [NENTRIES];

  logic [IDX_W-1:0] lk_idx;
  logic [TAG_W-1:0] lk_tag;
  logic [IDX_W-1:0] up_idx;
  logic [TAG_W-1:0] up_tag;
  logic             up_match;

  assign lk_idx = lookup_pc[TAG_LO-1:IDX_LO];
  assign lk_tag = lookup_pc[`BP_XLEN-1:TAG_LO];
  assign up_idx = update_pc[TAG_LO-1:IDX_LO];
  assign up_tag = update_pc[`BP_XLEN-1:TAG_LO];

  // Training only applies when the slot already belongs to this branch
  assign up_match = valid_q[up_idx] && (tag_mem[up_idx] == up_tag);

  // Registered tag compare
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hit <= 1'b0;
    end else begin
      hit <= valid_q[lk_idx] && (tag_mem[lk_idx] == lk_tag);
    end
  end

  // Entry payload and the pc it belongs to, for the fall-through address
  always_ff @(posedge clk) begin
    pred_tgt    <= tgt_mem[lk_idx];
    pred_ctr    <= ctr_mem[lk_idx];
    pred_kind   <= kind_mem[lk_idx];
    lookup_pc_q <= lookup_pc;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NENTRIES; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (update_en) begin
      valid_q[up_idx] <= 1'b1;
    end
  end

  // Allocate on miss or alias, train on tag match
  always_ff @(posedge clk) begin
    if (update_en) begin
      tag_mem[up_idx]  <= up_tag;
      tgt_mem[up_idx]  <= update_tgt;
      kind_mem[up_idx] <= update_kind;
      if (up_match) begin
        ctr_mem[up_idx] <= bp_pred_pkg::ctr_train(ctr_mem[up_idx], update_taken);
      end else begin
        ctr_mem[up_idx] <= bp_pred_pkg::ctr_init(update_taken);
      end
    end
  end

endmodule

// File: logic/return_stack.sv
`timescale 1ns/1ps

`include "bp_defines.svh"

module return_stack #(
  parameter int DEPTH = `BP_RAS_DEPTH
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push,
  input  logic             pop,
  input  bp_addr_pkg::pc_t push_addr,
  output bp_addr_pkg::pc_t top,
  output logic             empty
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  bp_addr_pkg::pc_t mem [DEPTH];

  // top_ptr points at the newest entry
  logic [PTR_W-1:0] top_ptr;
  logic [CNT_W-1:0] count;
  logic [PTR_W-1:0] next_ptr;
  logic             full;

  assign next_ptr = top_ptr + PTR_W'(1);
  assign full     = (count == CNT_W'(DEPTH));
  assign empty    = (count == '0);
  assign top      = mem[top_ptr];

  // Pointer and occupancy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      top_ptr <= '0;
      count   <= '0;
    end else begin
      if (push && pop) begin
        // Replace in place, an empty stack ends up holding one entry
        if (empty) count <= CNT_W'(1);
      end else if (push) begin
        // Pointer wraps onto the oldest entry once full
        top_ptr <= next_ptr;
        if (!full) count <= count + CNT_W'(1);
      end else if (pop && !empty) begin
        top_ptr <= top_ptr - PTR_W'(1);
        count   <= count - CNT_W'(1);
      end
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push && pop) begin
      mem[top_ptr] <= push_addr;
    end else if (push) begin
      mem[next_ptr] <= push_addr;
    end
  end

endmodule

// File: logic/fetch_predictor.sv
`timescale 1ns/1ps

module fetch_predictor (
  input  logic                      clk,
  input  logic                      rst_n,

  // Fetch side
  input  bp_addr_pkg::pc_t          lookup_pc,
  output logic                      hit,
  output logic                      predict_taken,
  output bp_addr_pkg::pc_t          next_pc,

  // Resolve side, BTB training
  input  logic                      update_en,
  input  bp_addr_pkg::pc_t          update_pc,
  input  bp_addr_pkg::pc_t          update_tgt,
  input  logic                      update_taken,
  input  bp_pred_pkg::branch_kind_t update_kind,

  // Resolve side, call and return tracking
  input  logic                      call_push,
  input  bp_addr_pkg::pc_t          call_ret_addr,
  input  logic                      ret_pop
);

  bp_addr_pkg::pc_t          pred_tgt;
  bp_pred_pkg::ctr_t         pred_ctr;
  bp_pred_pkg::branch_kind_t pred_kind;
  bp_addr_pkg::pc_t          lookup_pc_q;
  bp_addr_pkg::pc_t          ras_top;
  logic                      ras_empty;
  logic                      use_ras;

  btb btb_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .lookup_pc    (lookup_pc),
    .hit          (hit),
    .pred_tgt     (pred_tgt),
    .pred_ctr     (pred_ctr),
    .pred_kind    (pred_kind),
    .lookup_pc_q  (lookup_pc_q),
    .update_en    (update_en),
    .update_pc    (update_pc),
    .update_tgt   (update_tgt),
    .update_taken (update_taken),
    .update_kind  (update_kind)
  );

  return_stack ras_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (call_push),
    .pop       (ret_pop),
    .push_addr (call_ret_addr),
    .top       (ras_top),
    .empty     (ras_empty)
  );

  // Only conditional branches consult the counter, jumps and returns always redirect
  assign predict_taken = hit && ((pred_kind != bp_pred_pkg::kind_cond) ||
                                 bp_pred_pkg::ctr_taken(pred_ctr));

  // Returns prefer the stack, an empty stack falls back to the stored target
  assign use_ras = hit && (pred_kind == bp_pred_pkg::kind_ret) && !ras_empty;

  always_comb begin
    if (use_ras) begin
      next_pc = ras_top;
    end else if (predict_taken) begin
      next_pc = pred_tgt;
    end else begin
      next_pc = lookup_pc_q + bp_addr_pkg::INSN_BYTES;
    end
  end

endmodule

// File: tests/fetch_predictor_properties.sv
`timescale 1ns/1ps

module fetch_predictor_properties (
  input logic clk,
  input logic rst_n,
  input logic hit,
  input logic predict_taken,
  input logic call_push,
  input logic ret_pop,
  input logic ras_empty
);

  // Registered hit is cleared by every reset edge
  hit_after_reset: assert property (@(posedge clk) !rst_n |=> !hit)
    else $error("hit is set in the cycle after reset");

  taken_needs_hit: assert property (@(posedge clk) disable iff (!rst_n)
    predict_taken |-> hit)
    else $error("predict_taken is set without a BTB hit");

  // Pop on an empty stack is ignored
  pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
    (ret_pop && !call_push && ras_empty) |=> ras_empty)
    else $error("a return on an empty stack changed the stack");

endmodule

// File: tests/fetch_predictor_tb.sv
`timescale 1ns/1ps

`include "bp_defines.svh"

module fetch_predictor_tb;

  localparam int ENTRIES   = `BP_BTB_ENTRIES;
  localparam int RAS_DEPTH = `BP_RAS_DEPTH;
  localparam int TAG_LO    = 2 + $clog2(ENTRIES);
  localparam int N_RAND    = 300;
  // Cycle budget of reset and each test in run order
  localparam int RUN_CYCLES  = 18 + 34 + 30 + 40 + (N_RAND + 2) + 40 + 16;
  localparam int WATCHDOG_NS = RUN_CYCLES * 8 + 400;

  typedef struct packed {
    logic             hit;
    logic             taken;
    bp_addr_pkg::pc_t next_pc;
  } pred_t;

  logic                      clk;
  logic                      rst_n;
  bp_addr_pkg::pc_t          lookup_pc;
  logic                      hit;
  logic                      predict_taken;
  bp_addr_pkg::pc_t          next_pc;
  logic                      update_en;
  bp_addr_pkg::pc_t          update_pc;
  bp_addr_pkg::pc_t          update_tgt;
  logic                      update_taken;
  bp_pred_pkg::branch_kind_t update_kind;
  logic                      call_push;
  bp_addr_pkg::pc_t          call_ret_addr;
  logic                      ret_pop;

  // Reference model of the BTB arrays and the return stack
  logic                      m_valid [ENTRIES];
  logic [31:0]               m_tag   [ENTRIES];
  bp_addr_pkg::pc_t          m_tgt   [ENTRIES];
  int                        m_ctr   [ENTRIES];
  bp_pred_pkg::branch_kind_t m_kind  [ENTRIES];
  bp_addr_pkg::pc_t          ras_q   [$];

  // Strobes waiting for the next step
  logic                      pend_upd;
  logic                      pend_taken;
  logic                      pend_push;
  logic                      pend_pop;
  bp_addr_pkg::pc_t          pend_upc;
  bp_addr_pkg::pc_t          pend_utgt;
  bp_addr_pkg::pc_t          pend_raddr;
  bp_pred_pkg::branch_kind_t pend_kind;

  // Expected results and the cycle at which each one is due
  pred_t       exp_q [$];
  int          due_q [$];
  int          cycle_cnt = 0;
  logic [31:0] lfsr_q;
  string       test_name;
  int          tests_run = 0;
  int          checks = 0;
  int          errors = 0;
  int          test_errs = 0;

  fetch_predictor dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .lookup_pc     (lookup_pc),
    .hit           (hit),
    .predict_taken (predict_taken),
    .next_pc       (next_pc),
    .update_en     (update_en),
    .update_pc     (update_pc),
    .update_tgt    (update_tgt),
    .update_taken  (update_taken),
    .update_kind   (update_kind),
    .call_push     (call_push),
    .call_ret_addr (call_ret_addr),
    .ret_pop       (ret_pop)
  );

  bind fetch_predictor fetch_predictor_properties props_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .hit           (hit),
    .predict_taken (predict_taken),
    .call_push     (call_push),
    .ret_pop       (ret_pop),
    .ras_empty     (ras_empty)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // Expected outputs one cycle after a lookup of pc
  function automatic pred_t ref_predict(bp_addr_pkg::pc_t pc);
    int    idx;
    pred_t p;
    idx     = int'(pc[TAG_LO-1:2]);
    p.hit   = m_valid[idx] && (m_tag[idx] == (pc >> TAG_LO));
    p.taken = 1'b0;
    if (p.hit) begin
      p.taken = (m_kind[idx] == bp_pred_pkg::kind_cond) ? (m_ctr[idx] >= 2) : 1'b1;
    end
    if (p.hit && (m_kind[idx] == bp_pred_pkg::kind_ret) && (ras_q.size() != 0)) begin
      p.next_pc = ras_q[$];
    end else if (p.taken) begin
      p.next_pc = m_tgt[idx];
    end else begin
      p.next_pc = pc + 32'd4;
    end
    return p;
  endfunction

  task automatic btb_model_update(bp_addr_pkg::pc_t pc, bp_addr_pkg::pc_t tgt, logic taken,
                                  bp_pred_pkg::branch_kind_t kind);
    int idx;
    idx = int'(pc[TAG_LO-1:2]);
    if (m_valid[idx] && (m_tag[idx] == (pc >> TAG_LO))) begin
      if (taken) begin
        if (m_ctr[idx] < 3) m_ctr[idx]++;
      end else if (m_ctr[idx] > 0) begin
        m_ctr[idx]--;
      end
    end else begin
      m_valid[idx] = 1'b1;
      m_tag[idx]   = pc >> TAG_LO;
      m_ctr[idx]   = taken ? 2 : 1;
    end
    m_tgt[idx]  = tgt;
    m_kind[idx] = kind;
  endtask

  task automatic ras_model_update(logic push, logic pop, bp_addr_pkg::pc_t addr);
    if (push && pop) begin
      if (ras_q.size() == 0) ras_q.push_back(addr);
      else ras_q[ras_q.size()-1] = addr;
    end else if (push) begin
      // Full stack drops its oldest entry
      if (ras_q.size() == RAS_DEPTH) void'(ras_q.pop_front());
      ras_q.push_back(addr);
    end else if (pop && (ras_q.size() != 0)) begin
      void'(ras_q.pop_back());
    end
  endtask

  task automatic compare(string what, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
      errors++;
      test_errs++;
    end
  endtask

  always @(negedge clk) begin
    pred_t e;
    if ((due_q.size() != 0) && (due_q[0] == cycle_cnt)) begin
      e = exp_q.pop_front();
      void'(due_q.pop_front());
      compare("hit", 32'(e.hit), 32'(hit));
      compare("predict_taken", 32'(e.taken), 32'(predict_taken));
      compare("next_pc", e.next_pc, next_pc);
    end
  end

  task automatic queue_update(bp_addr_pkg::pc_t pc, bp_addr_pkg::pc_t tgt, logic taken,
                              bp_pred_pkg::branch_kind_t kind);
    pend_upd   = 1'b1;
    pend_upc   = pc;
    pend_utgt  = tgt;
    pend_taken = taken;
    pend_kind  = kind;
  endtask

  task automatic queue_call(bp_addr_pkg::pc_t addr);
    pend_push  = 1'b1;
    pend_raddr = addr;
  endtask

  task automatic queue_return();
    pend_pop = 1'b1;
  endtask

  // One cycle: lookup pc plus any queued strobes, expectation due next cycle
  task automatic step(bp_addr_pkg::pc_t pc);
    @(negedge clk);
    lookup_pc     = pc;
    update_en     = pend_upd;
    update_pc     = pend_upc;
    update_tgt    = pend_utgt;
    update_taken  = pend_taken;
    update_kind   = pend_kind;
    call_push     = pend_push;
    call_ret_addr = pend_raddr;
    ret_pop       = pend_pop;
    // The stack shows its state after the edge, the BTB its state before it
    ras_model_update(pend_push, pend_pop, pend_raddr);
    exp_q.push_back(ref_predict(pc));
    due_q.push_back(cycle_cnt + 1);
    if (pend_upd) btb_model_update(pend_upc, pend_utgt, pend_taken, pend_kind);
    pend_upd  = 1'b0;
    pend_push = 1'b0;
    pend_pop  = 1'b0;
  endtask

  task automatic begin_test(string name);
    test_name = name;
    test_errs = 0;
    tests_run++;
  endtask

  task automatic finish_test();
    @(negedge clk);
    update_en = 1'b0;
    call_push = 1'b0;
    ret_pop   = 1'b0;
    @(posedge clk);
    if (due_q.size() != 0) begin
      $display("%s: %0d expected results were never compared", test_name, due_q.size());
      errors++;
      test_errs++;
    end
    $display("%s: done, %0d errors", test_name, test_errs);
  endtask

  task automatic reset_miss();
    begin_test("reset_miss");
    for (int i = 0; i < 32; i++) begin
      step(32'h0000_2000 + 32'(i * 4));
    end
    finish_test();
  endtask

  task automatic counter_walk();
    logic [11:0] seq;
    // Taken pattern, first bit first, reaches both saturation ends
    seq = 12'hf07;
    begin_test("counter_walk");
    step(32'h0000_0100);
    for (int i = 0; i < 12; i++) begin
      queue_update(32'h0000_0100, 32'h0000_0800, seq[i], bp_pred_pkg::kind_cond);
      step(32'h0000_0100);
      step(32'h0000_0100);
    end
    queue_update(32'h0000_0104, 32'h0000_0900, 1'b0, bp_pred_pkg::kind_cond);
    step(32'h0000_0104);
    step(32'h0000_0104);
    finish_test();
  endtask

  task automatic alias_and_fill();
    begin_test("alias_and_fill");
    queue_update(32'h0000_1040, 32'h0000_a000, 1'b1, bp_pred_pkg::kind_jal);
    step(32'h0000_1040);
    step(32'h0000_1040);
    // Same index, different tag
    queue_update(32'h0000_2040, 32'h0000_b000, 1'b1, bp_pred_pkg::kind_jal);
    step(32'h0000_1040);
    step(32'h0000_1040);
    step(32'h0000_2040);
    for (int i = 0; i < ENTRIES; i++) begin
      queue_update(32'h0000_3000 + 32'(i * 4), 32'h0000_9000 + 32'(i * 16), 1'b1,
                   bp_pred_pkg::kind_cond);
      step(32'h0000_3000 + 32'(i * 4));
    end
    for (int i = 0; i < ENTRIES; i++) begin
      step(32'h0000_3000 + 32'(i * 4));
    end
    finish_test();
  endtask

  task automatic random_mix();
    bp_addr_pkg::pc_t          upc;
    bp_addr_pkg::pc_t          lpc;
    bp_addr_pkg::pc_t          tgt;
    bp_pred_pkg::branch_kind_t kind;
    logic [31:0]               r;
    begin_test("random_mix");
    for (int i = 0; i < N_RAND; i++) begin
      // Four tags over all indexes, so aliasing and hits are both common
      upc = 32'h0000_1000 | (take_bits(2) << 6);
      upc = upc | (take_bits(4) << 2);
      lpc = 32'h0000_1000 | (take_bits(2) << 6);
      lpc = lpc | (take_bits(4) << 2);
      tgt = 32'h0001_0000 | (take_bits(12) << 2);
      r = take_bits(2);
      kind = (r == 32'd1) ? bp_pred_pkg::kind_jal :
             (r == 32'd2) ? bp_pred_pkg::kind_ret : bp_pred_pkg::kind_cond;
      r = take_bits(2);
      if (r[1]) queue_update(upc, tgt, r[0], kind);
      r = take_bits(1);
      if (r[0]) lpc = upc;
      if (take_bits(3) == 32'd0) queue_call(tgt ^ 32'h0000_0100);
      if (take_bits(3) == 32'd0) queue_return();
      step(lpc);
    end
    finish_test();
  endtask

  task automatic return_stack_check();
    begin_test("return_stack_check");
    for (int i = 0; i < RAS_DEPTH; i++) begin
      queue_return();
      step(32'h0000_4000);
    end
    queue_update(32'h0000_4000, 32'h0000_4444, 1'b1, bp_pred_pkg::kind_ret);
    step(32'h0000_4000);
    step(32'h0000_4000);
    for (int i = 0; i < 3; i++) begin
      queue_call(32'h0000_6000 + 32'(i * 16));
      step(32'h0000_4000);
    end
    queue_return();
    step(32'h0000_4000);
    queue_call(32'h0000_6100);
    queue_return();
    step(32'h0000_4000);
    // Overflow keeps the newest entries
    for (int i = 0; i < RAS_DEPTH + 2; i++) begin
      queue_call(32'h0000_7000 + 32'(i * 16));
      step(32'h0000_4000);
    end
    for (int i = 0; i < RAS_DEPTH + 1; i++) begin
      queue_return();
      step(32'h0000_4000);
    end
    finish_test();
  endtask

  task automatic jal_always();
    begin_test("jal_always");
    queue_update(32'h0000_5008, 32'h0000_5100, 1'b1, bp_pred_pkg::kind_jal);
    step(32'h0000_5008);
    step(32'h0000_5008);
    for (int i = 0; i < 5; i++) begin
      queue_update(32'h0000_5008, 32'h0000_5200 + 32'(i * 16), 1'b0, bp_pred_pkg::kind_jal);
      step(32'h0000_5008);
      step(32'h0000_5008);
    end
    finish_test();
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before all tests finished", WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    lookup_pc     = '0;
    update_en     = 1'b0;
    update_pc     = '0;
    update_tgt    = '0;
    update_taken  = 1'b0;
    update_kind   = bp_pred_pkg::kind_cond;
    call_push     = 1'b0;
    call_ret_addr = '0;
    ret_pop       = 1'b0;
    pend_upd      = 1'b0;
    pend_taken    = 1'b0;
    pend_push     = 1'b0;
    pend_pop      = 1'b0;
    pend_upc      = '0;
    pend_utgt     = '0;
    pend_raddr    = '0;
    pend_kind     = bp_pred_pkg::kind_cond;
    lfsr_q        = 32'd69290;
    for (int i = 0; i < ENTRIES; i++) begin
      m_valid[i] = 1'b0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    reset_miss();
    counter_walk();
    alias_and_fill();
    random_mix();
    return_stack_check();
    jal_always();
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+logic
logic/bp_addr_pkg.sv
logic/bp_pred_pkg.sv
logic/btb.sv
logic/return_stack.sv
logic/fetch_predictor.sv
tests/fetch_predictor_properties.sv
tests/fetch_predictor_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the fetch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=fetch_predictor_sim

verilator --binary --timing --assert -Wno-fatal \
  --top-module fetch_predictor_tb \
  -f sources.f \
  --Mdir "$OBJ" -o "$BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" "$LOG"; then
  echo "Failure reported in $LOG"
  exit 1
fi
if ! grep -q "test passed" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
exit 0
